// ==== logic/ooo_pkg.sv ====
// Out-of-order back end types
`default_nettype none

package ooo_pkg;

  // Data word, also carries the pc
  typedef logic [31:0] word_t;

  // Destination register index
  typedef logic [4:0] reg_idx_t;

  // Opcode, codes 5 to 7 are illegal
  typedef logic [2:0] op_t;

  // Exception cause
  typedef logic [1:0] exc_t;

  localparam op_t OP_ADD = 3'd0;
  localparam op_t OP_SUB = 3'd1;
  localparam op_t OP_AND = 3'd2;
  localparam op_t OP_XOR = 3'd3;
  localparam op_t OP_MUL = 3'd4;

  localparam exc_t EXC_NONE     = 2'd0;
  localparam exc_t EXC_ILLEGAL  = 2'd1;
  // Signed overflow of add or subtract
  localparam exc_t EXC_OVERFLOW = 2'd2;

endpackage

`default_nettype wire

// ==== logic/ooo_ifs.sv ====
// Back end interconnect interfaces
`default_nettype none

// Slot allocation between dispatch and the completion buffer
interface cb_alloc_if #(
  parameter int TAG_W = 3
);
  import ooo_pkg::*;

  logic             alloc;
  reg_idx_t         rd;
  logic             wen;
  logic [TAG_W-1:0] tail;
  logic             full;
  logic             flush;

  modport disp (
    output alloc, rd, wen,
    input  tail, full, flush
  );

  modport cb (
    input  alloc, rd, wen,
    output tail, full, flush
  );
endinterface

// Instruction issue from dispatch into one lane
interface lane_issue_if #(
  parameter int TAG_W = 3
);
  import ooo_pkg::*;

  logic             issue;
  op_t              op;
  word_t            a;
  word_t            b;
  word_t            pc;
  logic [TAG_W-1:0] tag;
  logic             busy;

  modport disp (
    output issue, op, a, b, pc, tag,
    input  busy
  );

  modport lane (
    input  issue, op, a, b, pc, tag,
    output busy
  );
endinterface

// Result report from one lane into the completion buffer
interface lane_result_if #(
  parameter int TAG_W = 3
);
  import ooo_pkg::*;

  logic             done;
  logic [TAG_W-1:0] tag;
  // Holds the pc when exc is set
  word_t            data;
  exc_t             exc;

  modport lane (
    output done, tag, data, exc
  );

  modport cb (
    input  done, tag, data, exc
  );
endinterface

`default_nettype wire

// ==== logic/dispatch_unit.sv ====
// Instruction dispatch
`default_nettype none

module dispatch_unit #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              instr_valid,
  input  ooo_pkg::op_t      instr_op,
  input  ooo_pkg::reg_idx_t instr_rd,
  input  ooo_pkg::word_t    instr_a,
  input  ooo_pkg::word_t    instr_b,
  input  ooo_pkg::word_t    instr_pc,
  output logic              stall,
  cb_alloc_if.disp          alloc_if,
  lane_issue_if.disp        issue_if [NUM_LANES]
);

  localparam int TAG_W = $clog2(NUM_ENTRY);

  logic [NUM_LANES-1:0] lane_busy;
  logic [NUM_LANES-1:0] reserved;
  logic [NUM_LANES-1:0] lane_free;
  logic [NUM_LANES-1:0] issue_sel;
  logic                 any_free;
  logic                 accept;
  logic [TAG_W-1:0]     issue_tag;

  // Per-lane status in, issue strobe and operands out
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_busy[g]      = issue_if[g].busy;
    assign issue_if[g].issue = accept & issue_sel[g];
    assign issue_if[g].op    = instr_op;
    assign issue_if[g].a     = instr_a;
    assign issue_if[g].b     = instr_b;
    assign issue_if[g].pc    = instr_pc;
    assign issue_if[g].tag   = issue_tag;
  end

  // A lane issued last cycle still counts as taken until its busy shows up
  assign lane_free = ~lane_busy & ~reserved;
  assign any_free  = |lane_free;

  // Priority search, lowest free lane wins
  always_comb begin
    issue_sel = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_free[i] && issue_sel == '0) begin
        issue_sel[i] = 1'b1;
      end
    end
  end

  assign stall  = alloc_if.full | ~any_free | alloc_if.flush;
  assign accept = instr_valid & ~stall;

  // Slot allocation goes out with the issue in the same cycle
  assign alloc_if.alloc = accept;
  assign alloc_if.rd    = instr_rd;
  assign alloc_if.wen   = |instr_rd;
  assign issue_tag      = alloc_if.tail;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      reserved <= '0;
    end else begin
      reserved <= (reserved & ~lane_busy) | (issue_sel & {NUM_LANES{accept}});
    end
  end

  // Full comes from the buffer, alloc from here
  a_no_alloc_when_full: assert property (
    @(posedge CLK) disable iff (!nRST)
    alloc_if.full |-> !alloc_if.alloc
  );

endmodule

`default_nettype wire

// ==== logic/exec_lane.sv ====
// Integer execution lane
`default_nettype none

module exec_lane #(
  parameter int NUM_ENTRY = 8
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        flush,
  lane_issue_if.lane  issue_if,
  lane_result_if.lane result_if
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(NUM_ENTRY);

  typedef logic [TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    IDLE,
    MUL_STEP,
    REPORT
  } state_t;

  state_t     state;
  logic [1:0] step;
  tag_t       tag_q;
  word_t      a_q;
  word_t      b_q;
  word_t      acc;
  exc_t       exc_q;
  word_t      sum;
  word_t      diff;
  word_t      quick_res;
  exc_t       quick_exc;
  word_t      partial;

  assign sum  = issue_if.a + issue_if.b;
  assign diff = issue_if.a - issue_if.b;

  // Result known at issue; for multiply this is the first partial product
  always_comb begin
    quick_res = '0;
    quick_exc = EXC_NONE;
    case (issue_if.op)
      OP_ADD: begin
        quick_res = sum;
        if (issue_if.a[31] == issue_if.b[31] && sum[31] != issue_if.a[31]) begin
          quick_exc = EXC_OVERFLOW;
        end
      end
      OP_SUB: begin
        quick_res = diff;
        if (issue_if.a[31] != issue_if.b[31] && diff[31] != issue_if.a[31]) begin
          quick_exc = EXC_OVERFLOW;
        end
      end
      OP_AND:  quick_res = issue_if.a & issue_if.b;
      OP_XOR:  quick_res = issue_if.a ^ issue_if.b;
      OP_MUL:  quick_res = issue_if.a * {24'b0, issue_if.b[7:0]};
      default: quick_exc = EXC_ILLEGAL;
    endcase
    // Exceptions report the pc instead of a result
    if (quick_exc != EXC_NONE) begin
      quick_res = issue_if.pc;
    end
  end

  // Slice of b selected by the step count
  assign partial = a_q * {24'b0, b_q[{step, 3'b000} +: 8]};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      step  <= '0;
    end else if (flush) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (issue_if.issue) begin
            state <= (issue_if.op == OP_MUL) ? MUL_STEP : REPORT;
            step  <= 2'd1;
          end
        end
        MUL_STEP: begin
          step <= step + 2'd1;
          if (step == 2'd3) begin
            state <= REPORT;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && issue_if.issue) begin
      tag_q <= issue_if.tag;
      a_q   <= issue_if.a;
      b_q   <= issue_if.b;
      acc   <= quick_res;
      exc_q <= quick_exc;
    end else if (state == MUL_STEP) begin
      acc <= acc + (partial << {step, 3'b000});
    end
  end

  assign issue_if.busy  = state != IDLE;
  assign result_if.done = state == REPORT;
  assign result_if.tag  = tag_q;
  assign result_if.data = acc;
  assign result_if.exc  = exc_q;

  // Dispatch reservation must keep a working lane out of the search
  a_no_issue_when_busy: assert property (
    @(posedge CLK) disable iff (!nRST)
    issue_if.busy |-> !issue_if.issue
  );

endmodule

`default_nettype wire

// ==== logic/completion_buffer.sv ====
// In-order completion buffer
`default_nettype none

module completion_buffer #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3
) (
  input  logic              CLK,
  input  logic              nRST,
  cb_alloc_if.cb            alloc_if,
  lane_result_if.cb         result_if [NUM_LANES],
  output logic              commit_valid,
  output ooo_pkg::reg_idx_t commit_rd,
  output ooo_pkg::word_t    commit_data,
  output logic              commit_wen,
  output logic              exception,
  output ooo_pkg::exc_t     exc_cause,
  output ooo_pkg::word_t    epc
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(NUM_ENTRY);

  typedef logic [TAG_W-1:0] tag_t;
  // Pointer with one wrap bit above the slot index
  typedef logic [TAG_W:0] ptr_t;

  word_t                slot_data  [NUM_ENTRY];
  reg_idx_t             slot_rd    [NUM_ENTRY];
  logic                 slot_wen   [NUM_ENTRY];
  exc_t                 slot_cause [NUM_ENTRY];
  logic [NUM_ENTRY-1:0] slot_fin;

  ptr_t head;
  ptr_t tail;
  ptr_t count;
  tag_t head_idx;
  tag_t tail_idx;
  logic head_fin;
  logic head_exc;
  logic move_head;
  logic flush;

  logic [NUM_LANES-1:0] done_v;
  tag_t                 done_tag  [NUM_LANES];
  word_t                done_data [NUM_LANES];
  exc_t                 done_exc  [NUM_LANES];

  // One write port per lane
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_port
    tag_t offset;

    assign done_v[g]    = result_if[g].done;
    assign done_tag[g]  = result_if[g].tag;
    assign done_data[g] = result_if[g].data;
    assign done_exc[g]  = result_if[g].exc;

    // Distance from head, below count means the slot is in flight
    assign offset = done_tag[g] - head_idx;

    a_done_in_flight: assert property (
      @(posedge CLK) disable iff (!nRST)
      done_v[g] |-> (ptr_t'(offset) < count) && !slot_fin[done_tag[g]]
    );
  end

  assign head_idx = head[TAG_W-1:0];
  assign tail_idx = tail[TAG_W-1:0];
  assign count    = tail - head;

  assign alloc_if.tail  = tail_idx;
  assign alloc_if.full  = (head_idx == tail_idx) && (head[TAG_W] != tail[TAG_W]);
  assign alloc_if.flush = flush;

  // Head decides between commit and exception
  assign head_fin  = slot_fin[head_idx];
  assign head_exc  = slot_cause[head_idx] != EXC_NONE;
  assign move_head = head_fin & ~head_exc;
  assign flush     = head_fin & head_exc;

  assign commit_valid = move_head;
  assign commit_rd    = slot_rd[head_idx];
  assign commit_data  = slot_data[head_idx];
  assign commit_wen   = move_head & slot_wen[head_idx];
  assign exception    = flush;
  assign exc_cause    = slot_cause[head_idx];
  assign epc          = slot_data[head_idx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (move_head) begin
        head <= head + 1'b1;
      end
      if (alloc_if.alloc) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // Finished flags, cleared on commit and on flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      slot_fin <= '0;
    end else if (flush) begin
      slot_fin <= '0;
    end else begin
      if (move_head) begin
        slot_fin[head_idx] <= 1'b0;
      end
      for (int i = 0; i < NUM_LANES; i++) begin
        if (done_v[i]) begin
          slot_fin[done_tag[i]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (alloc_if.alloc) begin
      slot_rd[tail_idx]  <= alloc_if.rd;
      slot_wen[tail_idx] <= alloc_if.wen;
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      if (done_v[i]) begin
        slot_data[done_tag[i]]  <= done_data[i];
        slot_cause[done_tag[i]] <= done_exc[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/ooo_core_top.sv ====
// Out-of-order back end top
`default_nettype none

module ooo_core_top #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              instr_valid,
  input  ooo_pkg::op_t      instr_op,
  input  ooo_pkg::reg_idx_t instr_rd,
  input  ooo_pkg::word_t    instr_a,
  input  ooo_pkg::word_t    instr_b,
  input  ooo_pkg::word_t    instr_pc,
  output logic              stall,
  output logic              commit_valid,
  output ooo_pkg::reg_idx_t commit_rd,
  output ooo_pkg::word_t    commit_data,
  output logic              commit_wen,
  output logic              exception,
  output ooo_pkg::exc_t     exc_cause,
  output ooo_pkg::word_t    epc
);

  localparam int TAG_W = $clog2(NUM_ENTRY);

  cb_alloc_if    #(.TAG_W(TAG_W)) alloc_if ();
  lane_issue_if  #(.TAG_W(TAG_W)) issue_if  [NUM_LANES] ();
  lane_result_if #(.TAG_W(TAG_W)) result_if [NUM_LANES] ();

  dispatch_unit #(
    .NUM_ENTRY (NUM_ENTRY),
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr_op    (instr_op),
    .instr_rd    (instr_rd),
    .instr_a     (instr_a),
    .instr_b     (instr_b),
    .instr_pc    (instr_pc),
    .stall       (stall),
    .alloc_if    (alloc_if),
    .issue_if    (issue_if)
  );

  // Lanes share the buffer flush
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    exec_lane #(
      .NUM_ENTRY (NUM_ENTRY)
    ) u_lane (
      .CLK       (CLK),
      .nRST      (nRST),
      .flush     (alloc_if.flush),
      .issue_if  (issue_if[g]),
      .result_if (result_if[g])
    );
  end

  completion_buffer #(
    .NUM_ENTRY (NUM_ENTRY),
    .NUM_LANES (NUM_LANES)
  ) u_cb (
    .CLK          (CLK),
    .nRST         (nRST),
    .alloc_if     (alloc_if),
    .result_if    (result_if),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .commit_wen   (commit_wen),
    .exception    (exception),
    .exc_cause    (exc_cause),
    .epc          (epc)
  );

endmodule

`default_nettype wire

// ==== tests/commit_model.svh ====
// Commit reference model
`ifndef COMMIT_MODEL_SVH
`define COMMIT_MODEL_SVH

// Expected outcome of one accepted instruction
typedef struct packed {
  logic     is_exc;
  exc_t     cause;
  word_t    data;
  reg_idx_t rd;
  logic     wen;
} expect_t;

// Outstanding instructions in acceptance order
expect_t exp_q[$];

// Result or exception that an instruction must retire with
function automatic expect_t predict_outcome(op_t op, reg_idx_t rd, word_t a, word_t b,
                                            word_t pc);
  expect_t e;
  longint  sa;
  longint  sb;
  longint  wide;
  int      low;
  sa       = $signed(a);
  sb       = $signed(b);
  e.is_exc = 1'b0;
  e.cause  = EXC_NONE;
  e.data   = '0;
  e.rd     = rd;
  e.wen    = (rd != 5'd0);
  case (op)
    OP_ADD: wide = sa + sb;
    OP_SUB: wide = sa - sb;
    OP_AND: e.data = a & b;
    OP_XOR: e.data = a ^ b;
    OP_MUL: e.data = a * b;
    default: begin
      e.is_exc = 1'b1;
      e.cause  = EXC_ILLEGAL;
      e.data   = pc;
    end
  endcase
  if (op == OP_ADD || op == OP_SUB) begin
    low    = wide[31:0];
    e.data = wide[31:0];
    // Exact result does not fit in a signed word
    if (longint'(low) != wide) begin
      e.is_exc = 1'b1;
      e.cause  = EXC_OVERFLOW;
      e.data   = pc;
    end
  end
  return e;
endfunction

`endif

// ==== tests/ooo_core_tb.sv ====
// Out-of-order back end testbench
`default_nettype none

module ooo_core_tb;
  import ooo_pkg::*;

  `include "commit_model.svh"

  localparam int NUM_ENTRY    = 8;
  localparam int NUM_INSTR    = 3000;
  localparam int MAX_CYCLES   = 40000;
  localparam int DRAIN_CYCLES = 500;
  localparam int STALL_LIMIT  = 200;

  logic     CLK;
  logic     nRST;
  logic     instr_valid;
  op_t      instr_op;
  reg_idx_t instr_rd;
  word_t    instr_a;
  word_t    instr_b;
  word_t    instr_pc;
  logic     stall;
  logic     commit_valid;
  reg_idx_t commit_rd;
  word_t    commit_data;
  logic     commit_wen;
  logic     exception;
  exc_t     exc_cause;
  word_t    epc;

  int   seed = 32'ha40c_4687;
  int   accepted;
  int   cycles;
  int   burst_left;
  int   stall_run;
  int   n_commits;
  int   n_illegal;
  int   n_overflow;
  int   n_stalls;
  logic was_stalled;

  ooo_core_top #(
    .NUM_ENTRY (NUM_ENTRY)
  ) dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .instr_valid  (instr_valid),
    .instr_op     (instr_op),
    .instr_rd     (instr_rd),
    .instr_a      (instr_a),
    .instr_b      (instr_b),
    .instr_pc     (instr_pc),
    .stall        (stall),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .commit_wen   (commit_wen),
    .exception    (exception),
    .exc_cause    (exc_cause),
    .epc          (epc)
  );

  always #20 CLK = ~CLK;

  task automatic fail_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_field(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] time %0t %s expected %h got %h", $time, name, expected, actual);
      fail_run();
    end
  endtask

  function automatic int rand_below(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // Mostly small signed values so that overflow stays occasional
  function automatic word_t draw_operand();
    int v;
    v = $random(seed);
    if (rand_below(4) == 0) begin
      return v;
    end
    return v >>> 16;
  endfunction

  task automatic draw_instruction();
    if (burst_left > 0) begin
      burst_left--;
      instr_valid = 1'b1;
      instr_op    = OP_MUL;
    end else begin
      if (rand_below(50) == 0) begin
        burst_left = 12;
      end
      instr_valid = rand_below(10) < 8;
      if (rand_below(100) < 3) begin
        instr_op = op_t'(5 + rand_below(3));
      end else begin
        instr_op = op_t'(rand_below(5));
      end
    end
    instr_rd = reg_idx_t'(rand_below(32));
    instr_a  = draw_operand();
    instr_b  = draw_operand();
    instr_pc = word_t'($random(seed)) & 32'hffff_fffc;
  endtask

  // Outputs depend on DUT state only, so at the falling edge they hold for the next edge
  task automatic check_outputs();
    expect_t head;
    assert (!(commit_valid && exception)) else begin
      $display("Commit and exception raised together at time %0t", $time);
      fail_run();
    end
    if (commit_valid || exception) begin
      assert (exp_q.size() > 0) else begin
        $display("DUT retired an instruction at time %0t with none outstanding", $time);
        fail_run();
      end
      head = exp_q.pop_front();
      check_field("exception", 32'(head.is_exc), 32'(exception));
      if (commit_valid) begin
        check_field("commit_rd", 32'(head.rd), 32'(commit_rd));
        check_field("commit_data", head.data, commit_data);
        check_field("commit_wen", 32'(head.wen), 32'(commit_wen));
        n_commits++;
      end else begin
        check_field("exc_cause", 32'(head.cause), 32'(exc_cause));
        check_field("epc", head.data, epc);
        if (exc_cause == EXC_ILLEGAL) begin
          n_illegal++;
        end else begin
          n_overflow++;
        end
        // Everything younger is flushed
        exp_q.delete();
      end
    end
  endtask

  task automatic run_cycle(input logic allow_new);
    logic must_stall;
    @(negedge CLK);
    // Outstanding entries in the model equal the occupied buffer slots
    must_stall = (exp_q.size() == NUM_ENTRY) || exception;
    if (must_stall) begin
      check_field("stall", 32'd1, 32'(stall));
    end
    check_outputs();
    // Decoder holds a stalled instruction
    if (!(instr_valid && was_stalled)) begin
      if (allow_new) begin
        draw_instruction();
      end else begin
        instr_valid = 1'b0;
      end
    end
    was_stalled = stall;
    if (stall) begin
      stall_run++;
      n_stalls++;
    end else begin
      stall_run = 0;
    end
    assert (stall_run < STALL_LIMIT) else begin
      $display("Stall stayed high for %0d cycles at time %0t", stall_run, $time);
      fail_run();
    end
    if (instr_valid && !stall) begin
      exp_q.push_back(predict_outcome(instr_op, instr_rd, instr_a, instr_b, instr_pc));
      accepted++;
    end
  endtask

  initial begin
    CLK         = 1'b0;
    nRST        = 1'b0;
    instr_valid = 1'b0;
    instr_op    = OP_ADD;
    instr_rd    = '0;
    instr_a     = '0;
    instr_b     = '0;
    instr_pc    = '0;
    accepted    = 0;
    burst_left  = 0;
    stall_run   = 0;
    n_commits   = 0;
    n_illegal   = 0;
    n_overflow  = 0;
    n_stalls    = 0;
    was_stalled = 1'b0;

    repeat (8) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    check_field("commit_valid", 32'd0, 32'(commit_valid));
    check_field("exception", 32'd0, 32'(exception));
    check_field("stall", 32'd0, 32'(stall));

    cycles = 0;
    while (accepted < NUM_INSTR && cycles < MAX_CYCLES) begin
      run_cycle(1'b1);
      cycles++;
    end
    assert (accepted >= NUM_INSTR) else begin
      $display("Timed out with only %0d instructions accepted", accepted);
      fail_run();
    end

    // Drain until nothing is held or outstanding
    cycles = 0;
    while ((exp_q.size() != 0 || instr_valid) && cycles < DRAIN_CYCLES) begin
      run_cycle(1'b0);
      cycles++;
    end
    assert (exp_q.size() == 0 && !instr_valid) else begin
      $display("Drain timed out with %0d instructions outstanding", exp_q.size());
      fail_run();
    end
    repeat (10) run_cycle(1'b0);

    assert (n_commits > 0 && n_illegal > 0 && n_overflow > 0 && n_stalls > 0) else begin
      $display("Missing activity: %0d commits, %0d illegal, %0d overflow, %0d stalls",
               n_commits, n_illegal, n_overflow, n_stalls);
      fail_run();
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
logic/ooo_pkg.sv
logic/ooo_ifs.sv
logic/dispatch_unit.sv
logic/exec_lane.sv
logic/completion_buffer.sv
logic/ooo_core_top.sv
tests/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module ooo_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vooo_core_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Everything OK"; then
  exit 0
fi
exit 1
